//--- wb_ram_top.f
+incdir+.
wb_ram_pkg.sv
wb_bram_ctrl.sv
dual_port_bram.sv
dbg_mem_port.sv
wb_ram_top.sv
tb_wb_ram.sv

//--- run.sh
#!/bin/sh
# Compile the RAM slave testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f wb_ram_top.f --top-module tb_wb_ram -o sim_tb_wb_ram

output=$(./obj_dir/sim_tb_wb_ram 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_wb_ram_model.svh
/*
  Reference model for the RAM slave testbench: shadow memory, burst
  address order, byte-lane merge and the typed response compares.
  Included inside the testbench module.
*/
`ifndef TB_WB_RAM_MODEL_SVH
`define TB_WB_RAM_MODEL_SVH

logic [wb_ram_pkg::DW-1:0] shadow [0:wb_ram_pkg::DEPTH-1];

// address of the beat after addr, wrap bursts stay inside their aligned block
function automatic logic [wb_ram_pkg::AW-1:0] next_burst_addr(
    input logic [wb_ram_pkg::AW-1:0]   addr,
    input logic [wb_ram_pkg::BTEW-1:0] bte
);
    int blk;
    int base;
    int nxt;
    case (bte)
        wb_ram_pkg::BTE_WRAP4:  blk = 4;
        wb_ram_pkg::BTE_WRAP8:  blk = 8;
        wb_ram_pkg::BTE_WRAP16: blk = 16;
        default:                blk = wb_ram_pkg::DEPTH;   // linear rolls over at top
    endcase
    base = int'(addr) - (int'(addr) % blk);
    nxt  = base + ((int'(addr) % blk) + 1) % blk;
    return wb_ram_pkg::AW'(nxt);
endfunction

function automatic logic [wb_ram_pkg::DW-1:0] merge_bytes(
    input logic [wb_ram_pkg::DW-1:0]   old_word,
    input logic [wb_ram_pkg::DW-1:0]   new_word,
    input logic [wb_ram_pkg::SELW-1:0] sel
);
    logic [wb_ram_pkg::DW-1:0] res;
    res = old_word;
    for (int i = 0; i < wb_ram_pkg::SELW; i++) begin
        if (sel[i]) res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
endfunction

task automatic check_wb_rsp(input string name, input wb_ram_pkg::wb_rsp_t exp,
                            input wb_ram_pkg::wb_rsp_t act, input bit with_dat);
    if (exp.ack !== act.ack || exp.err !== act.err ||
        (with_dat && exp.dat !== act.dat)) begin
        $display("CHECK FAILED %s: expected ack=%b err=%b dat=%h actual ack=%b err=%b dat=%h",
                 name, exp.ack, exp.err, exp.dat, act.ack, act.err, act.dat);
        fatal_stop("wishbone response mismatch");
    end
endtask

task automatic check_dbg_rsp(input string name, input wb_ram_pkg::dbg_rsp_t exp,
                             input wb_ram_pkg::dbg_rsp_t act, input bit with_dat);
    if (exp.done !== act.done || exp.busy !== act.busy ||
        (with_dat && exp.rdata !== act.rdata)) begin
        $display("CHECK FAILED %s: expected done=%b busy=%b rdata=%h actual done=%b busy=%b rdata=%h",
                 name, exp.done, exp.busy, exp.rdata, act.done, act.busy, act.rdata);
        fatal_stop("debug response mismatch");
    end
endtask

`endif

//--- tb_wb_ram.sv
/*
  Testbench for the Wishbone RAM slave with debug port. Drives classic
  accesses, bursts, reserved cycles and debug commands, and a separate
  process compares every ack, err and done against the shadow model.
*/
`timescale 1ns/100ps

module tb_wb_ram;

    localparam int PLANNED_BEATS = 1024 + 24 + 32 + 32 + 2 + 4 + 18;
    localparam int CYCLE_LIMIT   = 4 * PLANNED_BEATS + 200;

    logic                 clk = 1'b0;
    logic                 arst_n_i;
    wb_ram_pkg::wb_req_t  wb_req;
    wb_ram_pkg::wb_rsp_t  wb_rsp;
    wb_ram_pkg::dbg_req_t dbg_req;
    wb_ram_pkg::dbg_rsp_t dbg_rsp;
    int                   seed = 31;
    int                   cycle_cnt = 0;
    bit                   stall_ack_ok = 1'b0;   // set for the cycle after stb drops mid-burst

    // expected responses in issue order
    wb_ram_pkg::wb_rsp_t  exp_wb_q[$];
    bit                   exp_wb_chk_q[$];
    string                exp_wb_name_q[$];
    wb_ram_pkg::dbg_rsp_t exp_dbg_q[$];
    bit                   exp_dbg_chk_q[$];
    string                exp_dbg_name_q[$];

    wb_ram_top u_dut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .dbg_req_i (dbg_req),
        .dbg_rsp_o (dbg_rsp)
    );

    always #2 clk = ~clk;

    task automatic fatal_stop(input string why);
        $display("error: %s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    `include "tb_wb_ram_model.svh"

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) fatal_stop("run did not finish within the cycle limit");
    end

    // response checker against the expected queues
    always @(negedge clk) begin
        if (arst_n_i && (wb_rsp.ack || wb_rsp.err)) begin
            if (!wb_req.stb) begin
                // only the ack of the beat held during back-pressure may linger
                if (!stall_ack_ok) fatal_stop("wishbone response while stb is low");
            end else if (exp_wb_q.size() == 0) begin
                fatal_stop("wishbone response with no access pending");
            end else begin
                check_wb_rsp(exp_wb_name_q.pop_front(), exp_wb_q.pop_front(), wb_rsp,
                             exp_wb_chk_q.pop_front());
            end
        end
        if (arst_n_i && dbg_rsp.done) begin
            if (exp_dbg_q.size() == 0) begin
                fatal_stop("debug done with no command pending");
            end else begin
                check_dbg_rsp(exp_dbg_name_q.pop_front(), exp_dbg_q.pop_front(), dbg_rsp,
                              exp_dbg_chk_q.pop_front());
            end
        end
    end

    task automatic wait_wb_rsp(input string name, input int want);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(wb_rsp.ack || wb_rsp.err));
        if (waited != want) begin
            $display("CHECK FAILED %s: ack latency expected %0d actual %0d", name, want, waited);
            fatal_stop("wishbone response latency");
        end
    endtask

    // classic access when classic is set, otherwise an incrementing burst
    task automatic wb_run(input string name, input bit we, input logic [wb_ram_pkg::AW-1:0] start,
                          input int n, input logic [wb_ram_pkg::BTEW-1:0] bte,
                          input bit classic, input int stall_at, input bit full_sel);
        logic [wb_ram_pkg::AW-1:0]   addr;
        logic [wb_ram_pkg::DW-1:0]   dat;
        logic [wb_ram_pkg::SELW-1:0] sel;
        logic [wb_ram_pkg::CTIW-1:0] cti;
        wb_ram_pkg::wb_rsp_t         exp;
        bit                          restart;
        addr    = start;
        restart = 1'b1;
        for (int k = 0; k < n; k++) begin
            dat = $random(seed);
            sel = full_sel ? '1 : wb_ram_pkg::SELW'($random(seed));
            cti = classic ? wb_ram_pkg::CTI_CLASSIC :
                  (k == n - 1) ? wb_ram_pkg::CTI_END : wb_ram_pkg::CTI_INCR;
            if (k == stall_at) begin
                @(posedge clk);
                wb_req.stb <= 1'b0;   // back-pressure for one cycle
                stall_ack_ok = 1'b1;
                @(posedge clk);
                stall_ack_ok = 1'b0;
                restart = 1'b1;
            end
            exp = '{ack: 1'b1, err: 1'b0, dat: '0};
            if (we) shadow[addr] = merge_bytes(shadow[addr], dat, sel);
            else exp.dat = shadow[addr];
            exp_wb_q.push_back(exp);
            exp_wb_chk_q.push_back(!we);
            exp_wb_name_q.push_back(name);
            @(posedge clk);
            wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, addr: addr, dat: dat,
                        cti: cti, bte: bte};
            wait_wb_rsp(name, restart ? 2 : 1);
            restart = classic;
            addr = next_burst_addr(addr, bte);
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_reserved(input string name, input logic [wb_ram_pkg::AW-1:0] addr);
        exp_wb_q.push_back('{ack: 1'b0, err: 1'b1, dat: '0});
        exp_wb_chk_q.push_back(1'b0);
        exp_wb_name_q.push_back(name);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: '1, addr: addr, dat: $random(seed),
                    cti: 3'b011, bte: wb_ram_pkg::BTE_LINEAR};
        wait_wb_rsp(name, 2);
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic dbg_cmd(input string name, input wb_ram_pkg::dbg_op_t op,
                           input logic [wb_ram_pkg::AW-1:0] addr,
                           input logic [wb_ram_pkg::DW-1:0] data, input int len);
        wb_ram_pkg::dbg_rsp_t exp;
        int                   waited;
        int                   busy_cycles;
        int                   want;
        exp  = '{done: 1'b1, busy: 1'b0, rdata: '0};
        want = (op == wb_ram_pkg::DBG_FILL) ? len + 2 : 2;
        if (op == wb_ram_pkg::DBG_WRITE) shadow[addr] = data;
        if (op == wb_ram_pkg::DBG_READ) exp.rdata = shadow[addr];
        if (op == wb_ram_pkg::DBG_FILL) begin
            for (int i = 0; i < len; i++) shadow[(int'(addr) + i) % wb_ram_pkg::DEPTH] = data;
        end
        exp_dbg_q.push_back(exp);
        exp_dbg_chk_q.push_back(op == wb_ram_pkg::DBG_READ);
        exp_dbg_name_q.push_back(name);
        @(posedge clk);
        dbg_req <= '{stb: 1'b1, op: op, addr: addr, data: data,
                     len: (wb_ram_pkg::AW+1)'(len)};
        @(posedge clk);
        dbg_req.stb <= 1'b0;
        waited      = 1;   // stb cycle already passed
        busy_cycles = 0;
        do begin
            @(negedge clk);
            waited++;
            if (dbg_rsp.busy) busy_cycles++;
        end while (!dbg_rsp.done);
        if (waited != want || busy_cycles != ((op == wb_ram_pkg::DBG_FILL) ? len : 0)) begin
            $display("CHECK FAILED %s: done after %0d busy %0d expected done after %0d",
                     name, waited, busy_cycles, want);
            fatal_stop("debug command timing");
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        wb_req   = '0;
        dbg_req  = '0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_wb_rsp("reset_wb", '{ack: 1'b0, err: 1'b0, dat: '0}, wb_rsp, 1'b0);
        check_dbg_rsp("reset_dbg", '{done: 1'b0, busy: 1'b0, rdata: '0}, dbg_rsp, 1'b0);

        // one linear burst over the whole memory for known contents
        wb_run("init_burst", 1'b1, '0, wb_ram_pkg::DEPTH, wb_ram_pkg::BTE_LINEAR, 1'b0, -1, 1'b1);

        for (int i = 0; i < 12; i++) wb_run("classic_wr", 1'b1, 10'(40 + i), 1, '0, 1'b1, -1, 1'b0);
        for (int i = 0; i < 12; i++) wb_run("classic_rd", 1'b0, 10'(40 + i), 1, '0, 1'b1, -1, 1'b0);

        wb_run("burst_rd_linear", 1'b0, 10'd13, 8, wb_ram_pkg::BTE_LINEAR, 1'b0, -1, 1'b0);
        wb_run("burst_rd_wrap4", 1'b0, 10'd6, 8, wb_ram_pkg::BTE_WRAP4, 1'b0, -1, 1'b0);
        wb_run("burst_rd_wrap8", 1'b0, 10'd45, 8, wb_ram_pkg::BTE_WRAP8, 1'b0, -1, 1'b0);
        wb_run("burst_rd_wrap16", 1'b0, 10'd1021, 8, wb_ram_pkg::BTE_WRAP16, 1'b0, -1, 1'b0);

        wb_run("burst_wr_wrap8", 1'b1, 10'd203, 8, wb_ram_pkg::BTE_WRAP8, 1'b0, -1, 1'b0);
        wb_run("burst_wr_stall", 1'b1, 10'd300, 8, wb_ram_pkg::BTE_LINEAR, 1'b0, 4, 1'b0);
        for (int i = 0; i < 8; i++) wb_run("burst_wr_chk", 1'b0, 10'(200 + i), 1, '0, 1'b1, -1, 1'b0);
        for (int i = 0; i < 8; i++) wb_run("stall_wr_chk", 1'b0, 10'(300 + i), 1, '0, 1'b1, -1, 1'b0);

        wb_reserved("reserved_cti", 10'd500);
        wb_run("reserved_chk", 1'b0, 10'd500, 1, '0, 1'b1, -1, 1'b0);

        dbg_cmd("dbg_write", wb_ram_pkg::DBG_WRITE, 10'd600, 32'hC0DE_1234, 1);
        wb_run("dbg_wr_chk", 1'b0, 10'd600, 1, '0, 1'b1, -1, 1'b0);
        wb_run("wb_wr_for_dbg", 1'b1, 10'd601, 1, '0, 1'b1, -1, 1'b1);
        dbg_cmd("dbg_read", wb_ram_pkg::DBG_READ, 10'd601, '0, 1);

        // fill wraps past the top word to address 3
        dbg_cmd("dbg_fill", wb_ram_pkg::DBG_FILL, 10'd1020, 32'hA5A5_5A5A, 8);
        for (int i = 0; i < 10; i++) begin
            wb_run("fill_chk", 1'b0, 10'((1019 + i) % wb_ram_pkg::DEPTH), 1, '0, 1'b1, -1, 1'b0);
        end

        @(posedge clk);
        if (exp_wb_q.size() == 0 && exp_dbg_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fatal_stop("some expected responses never arrived");
        end
    end

endmodule

//--- wb_ram_top.sv
/*
  On-chip RAM slave for a NoC tile. The Wishbone controller owns RAM
  port A, the debug engine owns port B. Bus and debug traffic run in
  parallel; they must not write the same word in the same cycle.
*/
`timescale 1ns/100ps

module wb_ram_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  wb_ram_pkg::wb_req_t  wb_req_i,
    output wb_ram_pkg::wb_rsp_t  wb_rsp_o,
    input  wb_ram_pkg::dbg_req_t dbg_req_i,
    output wb_ram_pkg::dbg_rsp_t dbg_rsp_o
);

    wb_ram_pkg::ram_port_t     ram_a;
    wb_ram_pkg::ram_port_t     ram_b;
    logic [wb_ram_pkg::DW-1:0] q_a;
    logic [wb_ram_pkg::DW-1:0] q_b;

    wb_bram_ctrl u_ctrl (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .ram_a_o  (ram_a),
        .q_a_i    (q_a)
    );

    dual_port_bram u_ram (
        .clk     (clk),
        .ram_a_i (ram_a),
        .ram_b_i (ram_b),
        .q_a_o   (q_a),
        .q_b_o   (q_b)
    );

    // debug side
    dbg_mem_port u_dbg (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .dbg_req_i (dbg_req_i),
        .dbg_rsp_o (dbg_rsp_o),
        .ram_b_o   (ram_b),
        .q_b_i     (q_b)
    );

endmodule

//--- dbg_mem_port.sv
/*
  Debug access engine on RAM port B. A one-cycle stb starts a single-word
  read or write, answered by done on the next cycle, or a fill that writes
  one word per cycle from addr for len words, wrapping at the top of the
  memory. Busy is high while a fill runs and no new stb is accepted then.
*/
`timescale 1ns/100ps

module dbg_mem_port (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  wb_ram_pkg::dbg_req_t      dbg_req_i,
    output wb_ram_pkg::dbg_rsp_t      dbg_rsp_o,
    output wb_ram_pkg::ram_port_t     ram_b_o,
    input  logic [wb_ram_pkg::DW-1:0] q_b_i
);

    logic                      busy_q;
    logic                      done_q;
    logic [wb_ram_pkg::AW:0]   cnt_q;         // words left to write
    logic [wb_ram_pkg::AW-1:0] fill_addr_q;
    logic [wb_ram_pkg::DW-1:0] fill_data_q;
    logic                      fill_start;
    logic                      last_word;

    assign fill_start = dbg_req_i.stb & (dbg_req_i.op == wb_ram_pkg::DBG_FILL);
    assign last_word  = (cnt_q == (wb_ram_pkg::AW+1)'(1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (fill_start) begin
                cnt_q  <= dbg_req_i.len;
                busy_q <= (dbg_req_i.len != '0);
                done_q <= (dbg_req_i.len == '0);   // empty fill finishes at once
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (last_word) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (dbg_req_i.stb) begin
                done_q <= 1'b1;   // single read or write
            end
        end
    end

    // fill value and running address
    always_ff @(posedge clk) begin
        if (fill_start) begin
            fill_addr_q <= dbg_req_i.addr;
            fill_data_q <= dbg_req_i.data;
        end else if (busy_q) begin
            fill_addr_q <= fill_addr_q + 1'b1;   // rolls over past the top word
        end
    end

    always_comb begin
        ram_b_o.be = '1;   // always whole words
        if (busy_q) begin
            ram_b_o.we    = 1'b1;
            ram_b_o.addr  = fill_addr_q;
            ram_b_o.wdata = fill_data_q;
        end else begin
            ram_b_o.we    = dbg_req_i.stb & (dbg_req_i.op == wb_ram_pkg::DBG_WRITE);
            ram_b_o.addr  = dbg_req_i.addr;
            ram_b_o.wdata = dbg_req_i.data;
        end
    end

    always_comb begin
        dbg_rsp_o.done  = done_q;
        dbg_rsp_o.busy  = busy_q;
        dbg_rsp_o.rdata = q_b_i;   // read word arrives with done
    end

    // host must wait for the fill to end
    no_stb_while_busy_a : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        dbg_req_i.stb |-> !busy_q
    );

endmodule

//--- dual_port_bram.sv
/*
  Generic true dual-port RAM, inferred from an array. Both ports write
  per byte lane and return the addressed word one clock later. A read of
  a word written on the same port in the same cycle returns the old word.
  Contents are undefined at power up.
*/
`timescale 1ns/100ps

module dual_port_bram (
    input  logic                      clk,
    input  wb_ram_pkg::ram_port_t     ram_a_i,
    input  wb_ram_pkg::ram_port_t     ram_b_i,
    output logic [wb_ram_pkg::DW-1:0] q_a_o,
    output logic [wb_ram_pkg::DW-1:0] q_b_o
);

    logic [wb_ram_pkg::DW-1:0] mem [0:wb_ram_pkg::DEPTH-1];

    // both ports in one process so the array has a single writer
    always_ff @(posedge clk) begin
        for (int i = 0; i < wb_ram_pkg::SELW; i++) begin
            if (ram_a_i.we && ram_a_i.be[i]) begin
                mem[ram_a_i.addr][i*8 +: 8] <= ram_a_i.wdata[i*8 +: 8];
            end
            if (ram_b_i.we && ram_b_i.be[i]) begin
                mem[ram_b_i.addr][i*8 +: 8] <= ram_b_i.wdata[i*8 +: 8];
            end
        end
    end

    // registered reads
    always_ff @(posedge clk) begin
        q_a_o <= mem[ram_a_i.addr];
        q_b_o <= mem[ram_b_i.addr];
    end

    /*
      Bus side and debug side are independent masters; a write on both
      ports to one word in the same cycle has no defined winner.
    */
    no_dual_write_a : assert property (
        @(posedge clk)
        !(ram_a_i.we && ram_b_i.we && (ram_a_i.addr == ram_b_i.addr))
    );

endmodule

//--- wb_bram_ctrl.sv
/*
  Wishbone slave front end of the on-chip RAM. Classic cycles are acked
  on their second cycle; incrementing bursts get ack on every cycle after
  the first beat, with the RAM address taken from an internal counter that
  follows the linear or wrap-4/8/16 order. Reserved cycle types get err.
  Drives RAM port A and returns its registered read data on the bus.
*/
`timescale 1ns/100ps

module wb_bram_ctrl (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  wb_ram_pkg::wb_req_t       wb_req_i,
    output wb_ram_pkg::wb_rsp_t       wb_rsp_o,
    output wb_ram_pkg::ram_port_t     ram_a_o,
    input  logic [wb_ram_pkg::DW-1:0] q_a_i
);

    logic                      ack_q;
    logic                      err_q;
    logic [wb_ram_pkg::AW-1:0] beat_addr_q;   // address of the beat being acked
    logic [wb_ram_pkg::AW-1:0] next_addr;
    logic                      req_valid;
    logic                      first_beat;
    logic                      cti_classic;
    logic                      cti_incr;
    logic                      cti_end;
    logic                      cti_rsvd;

    assign req_valid  = wb_req_i.cyc & wb_req_i.stb;
    assign first_beat = ~ack_q;   // previous beat not acked, start from bus address

    // cycle type decode
    always_comb begin
        cti_classic = (wb_req_i.cti == wb_ram_pkg::CTI_CLASSIC);
        cti_incr    = (wb_req_i.cti == wb_ram_pkg::CTI_INCR);
        cti_end     = (wb_req_i.cti == wb_ram_pkg::CTI_END);
        cti_rsvd    = ~(cti_classic | cti_incr | cti_end);
    end

    // next burst address, low bits wrap inside the aligned block
    always_comb begin
        next_addr = beat_addr_q;
        case (wb_req_i.bte)
            wb_ram_pkg::BTE_WRAP4:  next_addr[1:0] = beat_addr_q[1:0] + 2'd1;
            wb_ram_pkg::BTE_WRAP8:  next_addr[2:0] = beat_addr_q[2:0] + 3'd1;
            wb_ram_pkg::BTE_WRAP16: next_addr[3:0] = beat_addr_q[3:0] + 4'd1;
            default:                next_addr      = beat_addr_q + 1'b1;
        endcase
    end

    /*
      A read needs the address one cycle ahead of its ack, so during an
      ack cycle the RAM already sees the following beat. A write lands in
      the ack cycle itself and uses the address of the beat being acked.
    */
    always_comb begin
        ram_a_o.we    = ack_q & req_valid & wb_req_i.we & ~cti_rsvd;
        ram_a_o.be    = wb_req_i.sel;
        ram_a_o.wdata = wb_req_i.dat;
        if (first_beat) begin
            ram_a_o.addr = wb_req_i.addr;
        end else if (wb_req_i.we) begin
            ram_a_o.addr = beat_addr_q;
        end else begin
            ram_a_o.addr = next_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            // first beat always acked, later beats only while the burst continues
            ack_q <= req_valid & ~cti_rsvd & (first_beat | cti_incr);
            err_q <= req_valid & cti_rsvd & ~ack_q & ~err_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            beat_addr_q <= '0;
        end else if (req_valid) begin
            beat_addr_q <= first_beat ? wb_req_i.addr : next_addr;
        end
    end

    always_comb begin
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.err = err_q;
        wb_rsp_o.dat = q_a_i;   // valid together with ack
    end

    // one response kind per cycle
    ack_err_excl_a : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(wb_rsp_o.ack && wb_rsp_o.err)
    );

    // no ack without a cycle in progress one clock earlier
    ack_needs_cyc_a : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !wb_req_i.cyc |=> !wb_rsp_o.ack
    );

endmodule

//--- wb_ram_pkg.sv
/*
  Shared widths, Wishbone cycle and burst codes, and the bundles that
  connect the RAM slave blocks. Modules refer to these by scoped names.
  The memory holds DEPTH words of DW bits, addressed by word.
*/
package wb_ram_pkg;

    localparam int DW    = 32;          // data width
    localparam int AW    = 10;          // word address width
    localparam int SELW  = DW / 8;      // one select per byte lane
    localparam int DEPTH = 1 << AW;
    localparam int CTIW  = 3;
    localparam int BTEW  = 2;

    // cycle type identifiers, all other codes reserved
    localparam logic [CTIW-1:0] CTI_CLASSIC = 3'b000;
    localparam logic [CTIW-1:0] CTI_INCR    = 3'b010;
    localparam logic [CTIW-1:0] CTI_END     = 3'b111;

    // burst address ordering
    localparam logic [BTEW-1:0] BTE_LINEAR = 2'd0;
    localparam logic [BTEW-1:0] BTE_WRAP4  = 2'd1;
    localparam logic [BTEW-1:0] BTE_WRAP8  = 2'd2;
    localparam logic [BTEW-1:0] BTE_WRAP16 = 2'd3;

    // master to slave
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [SELW-1:0] sel;
        logic [AW-1:0]   addr;   // word address
        logic [DW-1:0]   dat;
        logic [CTIW-1:0] cti;
        logic [BTEW-1:0] bte;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic          ack;
        logic          err;
        logic [DW-1:0] dat;
    } wb_rsp_t;

    // one request on a RAM port
    typedef struct packed {
        logic            we;
        logic [SELW-1:0] be;
        logic [AW-1:0]   addr;
        logic [DW-1:0]   wdata;
    } ram_port_t;

    typedef enum logic [1:0] {
        DBG_READ  = 2'd0,
        DBG_WRITE = 2'd1,
        DBG_FILL  = 2'd2
    } dbg_op_t;

    typedef struct packed {
        logic          stb;    // single cycle pulse
        dbg_op_t       op;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [AW:0]   len;    // fill length in words
    } dbg_req_t;

    typedef struct packed {
        logic          done;
        logic          busy;
        logic [DW-1:0] rdata;
    } dbg_rsp_t;

endpackage
